// File: rtl/sm83_alu_pkg.sv
`default_nettype none

package sm83_alu_pkg;

	localparam int alu_width = 8;			// Data path width

	typedef logic [alu_width-1:0] alu_data_t;	// Operand or result byte
	typedef logic [3:0] alu_flags_t;		// Z N H C, Z on top
	typedef logic [2:0] bit_index_t;		// Bit select for BIT/SET/RES
	typedef logic [2:0] slice_ctl_t;		// Slice enables

	localparam int ctl_and = 2;			// Logic AND enable
	localparam int ctl_or = 1;			// Logic OR enable
	localparam int ctl_perm = 0;			// Shifter bypass enable

	typedef enum logic [4:0] {
		op_add = 5'h00,		// a + b
		op_adc = 5'h01,		// a + b + C
		op_sub = 5'h02,		// a - b
		op_sbc = 5'h03,		// a - b - C
		op_cp = 5'h04,		// Compare, difference on result
		op_and = 5'h05,
		op_xor = 5'h06,
		op_or = 5'h07,
		op_rlc = 5'h08,		// Rotate left circular
		op_rrc = 5'h09,		// Rotate right circular
		op_rl = 5'h0a,		// Rotate left through C
		op_rr = 5'h0b,		// Rotate right through C
		op_sla = 5'h0c,		// Shift left, zero fill
		op_sra = 5'h0d,		// Shift right, sign kept
		op_swap = 5'h0e,	// Nibble swap
		op_srl = 5'h0f,		// Shift right, zero fill
		op_bit = 5'h10,		// Test bit
		op_set = 5'h11,
		op_res = 5'h12,
		op_cpl = 5'h13,		// Complement a
		op_ccf = 5'h14,		// Complement carry
		op_scf = 5'h15		// Set carry
	} alu_op_t;

endpackage

`default_nettype wire

// File: rtl/alu_bit_slice.sv
`timescale 1ns/100ps
`default_nettype none

// One bit of the G/P array
// The G and P gates are shared with the AND/OR logic ops
module alu_bit_slice (
	input wire e,					// Preprocessed operand 1 bit
	input wire f,					// Operand 2 bit or its complement
	input wire perm,				// Shifter output bit
	input wire sm83_alu_pkg::slice_ctl_t ctl,	// Slice enables
	output logic gen,				// G term to the CLA
	output logic prop,				// P term to the CLA
	output logic half_sum,				// e ^ f and the XOR result
	output logic logic_term				// AND/OR/shift result bit
);
	import sm83_alu_pkg::*;

	logic and_sel;		// AND result gated
	logic or_sel;		// OR result gated
	logic perm_sel;		// Shifter bypass gated

	assign gen = e & f;		// Both set, carry generated
	assign prop = e | f;		// Either set, carry passes

	// P without G is the xor
	assign half_sum = prop & ~gen;

	assign and_sel = ctl[ctl_and] & gen;		// Reuse of G
	assign or_sel = ctl[ctl_or] & prop;		// Reuse of P
	assign perm_sel = ctl[ctl_perm] & perm;		// Shift result passes through

	// Only one enable is up per op
	assign logic_term = and_sel | or_sel | perm_sel;

endmodule

`default_nettype wire

// File: rtl/alu_carry_lookahead.sv
`timescale 1ns/100ps
`default_nettype none

// Nibble carry lookahead, all carries in two levels
module alu_carry_lookahead (
	input wire [3:0] gen,		// G terms of the nibble
	input wire [3:0] prop,		// P terms of the nibble
	input wire carry_in,		// Carry into bit 0
	output logic [3:0] carry	// Carries into bits 1..4
);

	assign carry[0] = gen[0]
		| (prop[0] & carry_in);
	assign carry[1] = gen[1]
		| (prop[1] & gen[0])
		| (prop[1] & prop[0] & carry_in);
	assign carry[2] = gen[2]
		| (prop[2] & gen[1])
		| (prop[2] & prop[1] & gen[0])
		| (prop[2] & prop[1] & prop[0] & carry_in);

	// Top carry, nibble carry out
	assign carry[3] = gen[3]
		| (prop[3] & gen[2])
		| (prop[3] & prop[2] & gen[1])
		| (prop[3] & prop[2] & prop[1] & gen[0])
		| (prop[3] & prop[2] & prop[1] & prop[0] & carry_in);

endmodule

`default_nettype wire

// File: rtl/alu_operand_stage.sv
`timescale 1ns/100ps
`default_nettype none

module alu_operand_stage (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	output logic in_ready,
	input wire sm83_alu_pkg::alu_op_t op,
	input wire sm83_alu_pkg::alu_data_t operand_a,
	input wire sm83_alu_pkg::alu_data_t operand_b,
	input wire sm83_alu_pkg::bit_index_t bit_index,
	output logic stage_valid,			// Pipeline register full
	input wire stage_ready,				// Result stage takes item
	output sm83_alu_pkg::alu_op_t stage_op,
	output logic tested_bit,			// a[bit_index] for BIT
	output sm83_alu_pkg::alu_data_t operand_a_q,
	output sm83_alu_pkg::alu_data_t slice_e,
	output sm83_alu_pkg::alu_data_t slice_f,
	output sm83_alu_pkg::alu_data_t slice_perm,
	output sm83_alu_pkg::slice_ctl_t slice_ctl
);
	import sm83_alu_pkg::*;

	alu_data_t bit_mask;		// One-hot of bit_index
	alu_data_t shift_out;		// Shifter result
	alu_data_t e_next;
	alu_data_t f_next;
	slice_ctl_t ctl_next;
	logic accept;			// Input transfer

	assign in_ready = ~stage_valid | stage_ready;	// Empty or draining
	assign accept = in_valid & in_ready;

	assign bit_mask = alu_data_t'(1) << bit_index;

	// Shifter on operand a
	always_comb begin
		case (op)
			op_rlc: shift_out = {operand_a[6:0], operand_a[7]};
			op_rrc: shift_out = {operand_a[0], operand_a[7:1]};
			op_rl: shift_out = {operand_a[6:0], 1'b0};	// C inserted later
			op_rr: shift_out = {1'b0, operand_a[7:1]};	// C inserted later
			op_sla: shift_out = {operand_a[6:0], 1'b0};
			op_sra: shift_out = {operand_a[7], operand_a[7:1]};	// Sign kept
			op_swap: shift_out = {operand_a[3:0], operand_a[7:4]};
			op_srl: shift_out = {1'b0, operand_a[7:1]};
			default: shift_out = '0;
		endcase
	end

	// Slice operands and enables
	always_comb begin
		e_next = operand_a;
		f_next = operand_b;
		ctl_next = '0;
		case (op)
			op_sub, op_sbc, op_cp: f_next = ~operand_b;	// a + ~b + cin
			op_and: ctl_next[ctl_and] = 1'b1;
			op_or: ctl_next[ctl_or] = 1'b1;
			op_rlc, op_rrc, op_rl, op_rr,
			op_sla, op_sra, op_swap, op_srl: begin
				e_next = '0;
				f_next = '0;
				ctl_next[ctl_perm] = 1'b1;		// Shifter bypass
			end
			op_bit: begin
				f_next = '0;
				ctl_next[ctl_or] = 1'b1;		// a passes to result
			end
			op_set: begin
				e_next = operand_a | bit_mask;
				f_next = '0;
				ctl_next[ctl_or] = 1'b1;
			end
			op_res: begin
				e_next = operand_a & ~bit_mask;
				f_next = '0;
				ctl_next[ctl_or] = 1'b1;
			end
			op_cpl, op_ccf, op_scf: begin
				e_next = '0;				// Result from operand_a_q
				f_next = '0;
			end
			default: begin
				e_next = operand_a;			// ADD, ADC, XOR
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_valid <= 1'b0;
		end else if (in_ready) begin
			stage_valid <= in_valid;		// Load or empty
		end
	end

	// Payload only moves on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			stage_op <= op;
			tested_bit <= operand_a[bit_index];
			operand_a_q <= operand_a;
			slice_e <= e_next;
			slice_f <= f_next;
			slice_perm <= shift_out;
			slice_ctl <= ctl_next;
		end
	end

endmodule

`default_nettype wire

// File: rtl/alu_result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module alu_result_stage (
	input wire clk,
	input wire rst_n,
	input wire stage_valid,
	output logic stage_ready,
	input wire sm83_alu_pkg::alu_op_t stage_op,
	input wire tested_bit,
	input wire sm83_alu_pkg::alu_data_t operand_a_q,
	input wire sm83_alu_pkg::alu_data_t gen,		// From slices
	input wire sm83_alu_pkg::alu_data_t prop,
	input wire sm83_alu_pkg::alu_data_t half_sum,
	input wire sm83_alu_pkg::alu_data_t logic_term,
	output logic out_valid,
	input wire out_ready,
	output sm83_alu_pkg::alu_data_t result,
	output sm83_alu_pkg::alu_flags_t flags		// Z N H C
);
	import sm83_alu_pkg::*;

	logic flag_z;			// Stored flags
	logic flag_c;
	logic carry_in;			// Carry into bit 0
	logic [3:0] carry_lo;		// Carries into bits 1..4
	logic [3:0] carry_hi;		// Carries into bits 5..8
	logic half_carry;		// Out of bit 3
	logic full_carry;		// Out of bit 7
	alu_data_t carry_into;		// Carry into each bit
	alu_data_t sum;
	alu_data_t result_next;
	alu_flags_t flags_next;
	logic zero;			// Result is zero
	logic transfer;

	assign flag_z = flags[3];
	assign flag_c = flags[0];

	always_comb begin
		case (stage_op)
			op_adc: carry_in = flag_c;
			op_sub, op_cp: carry_in = 1'b1;		// Two's complement +1
			op_sbc: carry_in = ~flag_c;		// Borrow subtracts the +1
			default: carry_in = 1'b0;
		endcase
	end

	alu_carry_lookahead u_cla_lo (
		.gen(gen[3:0]),
		.prop(prop[3:0]),
		.carry_in(carry_in),
		.carry(carry_lo)
	);

	alu_carry_lookahead u_cla_hi (
		.gen(gen[7:4]),
		.prop(prop[7:4]),
		.carry_in(carry_lo[3]),			// Chained on nibble carry
		.carry(carry_hi)
	);

	assign half_carry = carry_lo[3];
	assign full_carry = carry_hi[3];
	assign carry_into = {carry_hi[2:0], carry_lo, carry_in};
	assign sum = half_sum ^ carry_into;

	always_comb begin
		case (stage_op)
			op_add, op_adc, op_sub, op_sbc, op_cp: result_next = sum;
			op_xor: result_next = half_sum;
			op_rl: result_next = {logic_term[7:1], flag_c};	// Old C into bit 0
			op_rr: result_next = {flag_c, logic_term[6:0]};	// Old C into bit 7
			op_cpl: result_next = ~operand_a_q;
			op_ccf, op_scf: result_next = operand_a_q;
			default: result_next = logic_term;	// AND, OR, shifts, BIT/SET/RES
		endcase
	end

	assign zero = (result_next == '0);

	always_comb begin
		case (stage_op)
			op_add, op_adc: flags_next = {zero, 1'b0, half_carry, full_carry};
			op_sub, op_sbc, op_cp: flags_next = {zero, 1'b1, ~half_carry, ~full_carry};
			op_and: flags_next = {zero, 3'b010};
			op_xor, op_or, op_swap: flags_next = {zero, 3'b000};
			op_rlc, op_rl, op_sla: flags_next = {zero, 2'b00, operand_a_q[7]};
			op_rrc, op_rr, op_sra, op_srl: flags_next = {zero, 2'b00, operand_a_q[0]};
			op_bit: flags_next = {~tested_bit, 2'b01, flag_c};
			op_cpl: flags_next = {flag_z, 2'b11, flag_c};
			op_ccf: flags_next = {flag_z, 2'b00, ~flag_c};
			op_scf: flags_next = {flag_z, 3'b001};
			default: flags_next = flags;		// SET, RES
		endcase
	end

	assign stage_ready = ~out_valid | out_ready;	// Output empty or leaving
	assign transfer = stage_valid & stage_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			flags <= '0;
		end else begin
			if (stage_ready) begin
				out_valid <= stage_valid;
			end
			if (transfer) begin
				flags <= flags_next;		// Update in request order
			end
		end
	end

	always_ff @(posedge clk) begin
		if (transfer) begin
			result <= result_next;			// Held while stalled
		end
	end

endmodule

`default_nettype wire

// File: rtl/sm83_alu.sv
`timescale 1ns/100ps
`default_nettype none

module sm83_alu (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	output logic in_ready,
	input wire sm83_alu_pkg::alu_op_t op,
	input wire sm83_alu_pkg::alu_data_t operand_a,
	input wire sm83_alu_pkg::alu_data_t operand_b,
	input wire sm83_alu_pkg::bit_index_t bit_index,
	output logic out_valid,
	input wire out_ready,
	output sm83_alu_pkg::alu_data_t result,
	output sm83_alu_pkg::alu_flags_t flags
);
	import sm83_alu_pkg::*;

	logic stage_valid;		// Operand stage to result stage
	logic stage_ready;
	alu_op_t stage_op;
	logic tested_bit;
	alu_data_t operand_a_q;
	alu_data_t slice_e;		// Operand stage to slices
	alu_data_t slice_f;
	alu_data_t slice_perm;
	slice_ctl_t slice_ctl;
	alu_data_t gen;			// Slices to result stage
	alu_data_t prop;
	alu_data_t half_sum;
	alu_data_t logic_term;

	alu_operand_stage u_operand (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.op(op),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.bit_index(bit_index),
		.stage_valid(stage_valid),
		.stage_ready(stage_ready),
		.stage_op(stage_op),
		.tested_bit(tested_bit),
		.operand_a_q(operand_a_q),
		.slice_e(slice_e),
		.slice_f(slice_f),
		.slice_perm(slice_perm),
		.slice_ctl(slice_ctl)
	);

	for (genvar i = 0; i < alu_width; i++) begin : g_slice
		alu_bit_slice u_slice (
			.e(slice_e[i]),
			.f(slice_f[i]),
			.perm(slice_perm[i]),
			.ctl(slice_ctl),			// Same enables for every bit
			.gen(gen[i]),
			.prop(prop[i]),
			.half_sum(half_sum[i]),
			.logic_term(logic_term[i])
		);
	end

	alu_result_stage u_result (
		.clk(clk),
		.rst_n(rst_n),
		.stage_valid(stage_valid),
		.stage_ready(stage_ready),
		.stage_op(stage_op),
		.tested_bit(tested_bit),
		.operand_a_q(operand_a_q),
		.gen(gen),
		.prop(prop),
		.half_sum(half_sum),
		.logic_term(logic_term),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.flags(flags)
	);

endmodule

`default_nettype wire

// File: verification/tb_sm83_alu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sm83_alu;
	import sm83_alu_pkg::*;

	localparam int max_vectors = 64;		// Room in the vector memory
	localparam int vector_words = 6;		// op, a, b, bit, result, flags

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	alu_op_t op;
	alu_data_t operand_a;
	alu_data_t operand_b;
	bit_index_t bit_index;
	logic out_valid;
	logic out_ready;
	alu_data_t result;
	alu_flags_t flags;

	logic [7:0] vectors [0:max_vectors*vector_words-1];	// Loaded from the hex file
	int vector_count;		// Vectors before the end marker
	int sent;			// Input transfers so far
	int received;			// Output transfers so far
	int cycles;
	int cycle_limit;
	logic took;			// Input transfer at the coming edge
	logic [31:0] rng;		// LCG state

	sm83_alu dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.op(op),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.bit_index(bit_index),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;		// 40 ns period
	end

	// Numerical Recipes constants
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h, vector %0d",
				name, got, expected, received);
			$display("TB FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic present_vector(input int index);
		in_valid <= 1'b1;
		op <= alu_op_t'(vectors[index*vector_words][4:0]);
		operand_a <= vectors[index*vector_words+1];
		operand_b <= vectors[index*vector_words+2];
		bit_index <= vectors[index*vector_words+3][2:0];
	endtask

	// Reset, then driver for inputs and out_ready
	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		op = op_add;
		operand_a = '0;
		operand_b = '0;
		bit_index = '0;
		out_ready = 1'b0;
		sent = 0;
		received = 0;
		took = 1'b0;
		rng = 32'd32;			// Seed
		$readmemh("verification/alu_stimulus.hex", vectors);
		vector_count = 0;
		while (vector_count < max_vectors
			&& vectors[vector_count*vector_words] !== 8'hff) begin
			vector_count++;		// Stop at the ff marker
		end
		cycle_limit = 8 * vector_count + 50;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		while (received < vector_count) begin
			@(negedge clk);
			took = in_valid && in_ready;	// Settled mid-cycle
			@(posedge clk);
			rng = lcg_next(rng);
			out_ready <= (rng[25:24] != 2'd0);	// Stall about one cycle in four
			if (took) begin
				sent++;
			end
			// A pending request stays put until taken
			if (!in_valid || took) begin
				if (sent < vector_count && rng[29:28] != 2'd0) begin
					present_vector(sent);
				end else begin
					in_valid <= 1'b0;	// Gap or done
				end
			end
		end
		in_valid <= 1'b0;
		out_ready <= 1'b1;		// Any extra output would show now
		repeat (4) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

	// Monitor, sampled at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (!(out_valid && !out_ready)) begin
				check_value("in_ready", {7'd0, in_ready}, 8'h01);	// Stall only from output
			end
			if (out_valid && out_ready) begin
				if (received >= vector_count) begin
					$display("Output transfer seen after the last vector was checked");
					$display("TB FAILED");
					$fatal(1, "Extra output");
				end else begin
					check_value("result", result, vectors[received*vector_words+4]);
					check_value("flags", {4'd0, flags}, vectors[received*vector_words+5]);
					received++;
				end
			end
		end
	end

	// Watchdog
	initial begin
		cycles = 0;
		@(posedge clk);
		cycles = 1;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: outputs stopped arriving, %0d of %0d vectors seen",
			received, vector_count);
		$display("TB FAILED");
		$fatal(1, "Timeout");
	end

endmodule

`default_nettype wire

// File: verification/alu_stimulus.hex
// op a b bit result flags, one vector per line, ff row ends the list
// flags nibble is Z N H C with Z = 8, starting from 0 after reset
00 0f 01 00 10 02
00 ff 01 00 00 0b
01 10 20 00 31 00
00 80 80 00 00 09
01 0e 01 00 10 02
02 10 01 00 0f 06
02 05 05 00 00 0c
02 00 01 00 ff 07
03 20 10 00 0f 06
03 05 03 00 02 04
04 3c 40 00 fc 05
04 3c 3c 00 00 0c
05 f0 3c 00 30 02
05 0f f0 00 00 0a
06 a5 ff 00 5a 00
06 3c 3c 00 00 08
07 50 0a 00 5a 00
07 00 00 00 00 08
08 85 00 00 0b 01
09 01 00 00 80 01
0a 80 00 00 01 01
0a 11 00 00 23 00
0b 01 00 00 00 09
0b 02 00 00 81 00
0c 81 00 00 02 01
0d 81 00 00 c0 01
0e f1 00 00 1f 00
0f 01 00 00 00 09
10 fe 00 00 fe 0b
10 08 00 03 08 03
10 bf 00 06 bf 0b
11 00 00 01 02 0b
11 0f 00 04 1f 0b
11 7f 00 07 ff 0b
12 ff 00 02 fb 0b
12 20 00 05 00 0b
13 35 00 00 ca 0f
14 12 00 00 12 08
15 34 00 00 34 09
ff ff ff ff ff ff

// File: sources.f
rtl/sm83_alu_pkg.sv
rtl/alu_bit_slice.sv
rtl/alu_carry_lookahead.sv
rtl/alu_operand_stage.sv
rtl/alu_result_stage.sv
rtl/sm83_alu.sv
verification/tb_sm83_alu.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing -j 0
TOP       := tb_sm83_alu
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(wildcard rtl/*.sv verification/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
